// File: design/sdram_sched_pkg.sv
package sdram_sched_pkg;

	localparam int SDRAM_DEPTH = 25; // Byte address width.
	localparam int COL_W = 8;
	localparam int ROW_W = SDRAM_DEPTH - 2 - COL_W - 2; // Fills the 13-bit address bus.
	localparam int WORD_W = SDRAM_DEPTH - 3; // Address of a 64-bit word.
	localparam int BANK_N = 4;
	localparam int READ_BURST_LEN = 4;
	localparam int WRITE_BURST_LEN = 4;

	typedef logic [WORD_W-1:0] word_adr_t;
	typedef logic [ROW_W-1:0] row_t;
	typedef logic [COL_W-1:0] col_t;
	typedef logic [$clog2(BANK_N)-1:0] bank_t;

	// Active-high command bits, inverted on the way to the pins.
	typedef struct packed {
		logic cs;
		logic ras;
		logic cas;
		logic we;
	} sdram_cmd_t;

	localparam sdram_cmd_t CMD_NOP = 4'b0000;
	localparam sdram_cmd_t CMD_ACTIVATE = 4'b1100;
	localparam sdram_cmd_t CMD_READ = 4'b1010;
	localparam sdram_cmd_t CMD_WRITE = 4'b1011;
	localparam sdram_cmd_t CMD_PRECHARGE = 4'b1101;
	localparam sdram_cmd_t CMD_REFRESH = 4'b1110;

	localparam row_t A10_ALL = row_t'(1024); // Selects all banks on PRECHARGE.

	typedef enum logic [2:0] {
		IDLE,
		ACTIVATE,
		READ,
		WRITE,
		PRECHARGEALL,
		AUTOREFRESH,
		AUTOREFRESH_WAIT
	} cmd_state_t;

	typedef enum logic [1:0] {
		WIDLE,
		WPROCESS_READ,
		WPROCESS_WRITE
	} bus_state_t;

endpackage

// File: design/sched_req_if.sv
`timescale 1ns/1ps

interface sched_req_if #(
	parameter int ADR_W = 1
);

	logic             head_valid;
	logic             head_we;
	logic [ADR_W-1:0] head_adr;
	logic             read_pending; // Issued read not yet consumed by the bus side.
	logic             write_pending;
	logic [ADR_W-1:0] fetched_adr;
	logic             advance; // Pulses when a READ or WRITE leaves the head.
	logic             clear_fetch;

	modport queue (
		output head_valid, head_we, head_adr, read_pending, write_pending, fetched_adr,
		input  advance, clear_fetch
	);
	modport cmd (
		input  head_valid, head_we, read_pending, write_pending, clear_fetch,
		output advance
	);
	modport bus (
		input  read_pending, write_pending, fetched_adr,
		output clear_fetch
	);

endinterface

// File: design/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
	input  logic        sdram_rst,
	input  logic        sys_clk,
	input  logic [31:0] adr_i,
	input  logic        we_i,
	input  logic        req_i,
	input  logic        ack_i,
	sched_req_if.queue  q
);

	logic                       bus_req;
	logic                       bus_we;
	sdram_sched_pkg::word_adr_t bus_adr;
	logic                       next_valid;
	logic                       next_we;
	sdram_sched_pkg::word_adr_t next_adr;
	logic                       hit_next;
	logic                       hit_head;
	logic                       hit_issued;
	logic                       req_valid;

	always_ff @(posedge sdram_rst or posedge sys_clk) begin
		if (sys_clk) begin
			bus_req <= 1'b0;
		end else begin
			bus_req <= req_i & ~ack_i; // An acknowledged access must not be queued again.
		end
	end

	always_ff @(posedge sdram_rst) begin
		bus_we  <= we_i;
		bus_adr <= adr_i[sdram_sched_pkg::SDRAM_DEPTH-1:3];
	end

	// A held bus request is seen every cycle, so copies anywhere in the queue are dropped.
	assign hit_next = next_valid & (bus_adr == next_adr) & (bus_we == next_we);
	assign hit_head = q.head_valid & (bus_adr == q.head_adr) & (bus_we == q.head_we);
	assign hit_issued = (q.read_pending | q.write_pending) & (bus_adr == q.fetched_adr)
		& (bus_we == q.write_pending);
	assign req_valid = bus_req & ~hit_next & ~hit_head & ~hit_issued;

	always_ff @(posedge sdram_rst or posedge sys_clk) begin
		if (sys_clk) begin
			next_valid      <= 1'b0;
			q.head_valid    <= 1'b0;
			q.read_pending  <= 1'b0;
			q.write_pending <= 1'b0;
		end else if (q.advance) begin
			q.read_pending  <= q.head_valid & ~q.head_we; // Head moves to the issued slot.
			q.write_pending <= q.head_valid & q.head_we;
			q.head_valid    <= next_valid;
			next_valid      <= 1'b0;
		end else begin
			if (q.clear_fetch) begin
				q.read_pending  <= 1'b0;
				q.write_pending <= 1'b0;
			end
			if (req_valid & ~q.head_valid) begin
				q.head_valid <= 1'b1;
			end else if (req_valid & ~next_valid) begin
				next_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge sdram_rst) begin
		if (q.advance) begin
			q.fetched_adr <= q.head_adr;
			q.head_we     <= next_we;
			q.head_adr    <= next_adr;
		end else if (req_valid & ~q.head_valid) begin
			q.head_we  <= bus_we;
			q.head_adr <= bus_adr;
		end else if (req_valid & ~next_valid) begin
			next_we  <= bus_we;
			next_adr <= bus_adr;
		end
	end

endmodule

// File: design/open_row_tracker.sv
`timescale 1ns/1ps

module open_row_tracker (
	input  logic                                sdram_rst,
	input  logic                                sys_clk,
	input  sdram_sched_pkg::word_adr_t          head_adr_i,
	input  logic [sdram_sched_pkg::BANK_N-1:0] open_i,
	input  logic [sdram_sched_pkg::BANK_N-1:0] close_i,
	output sdram_sched_pkg::row_t               row_o,
	output sdram_sched_pkg::col_t               col_o,
	output sdram_sched_pkg::bank_t              bank_o,
	output logic                                bank_open_o,
	output logic                                page_hit_o
);

	localparam int BANK_W = $bits(sdram_sched_pkg::bank_t);
	localparam int COL_W = sdram_sched_pkg::COL_W;

	logic [sdram_sched_pkg::WORD_W:0]   adr32; // Address of a 32-bit word.
	logic [sdram_sched_pkg::BANK_N-1:0] has_open;
	sdram_sched_pkg::row_t              open_rows [sdram_sched_pkg::BANK_N];

	// Row, then bank, then column, counted in 32-bit words.
	assign adr32 = {head_adr_i, 1'b0};
	assign col_o = adr32[COL_W-1:0];
	assign bank_o = adr32[COL_W+BANK_W-1:COL_W];
	assign row_o = adr32[sdram_sched_pkg::WORD_W:COL_W+BANK_W];

	always_ff @(posedge sdram_rst or posedge sys_clk) begin
		if (sys_clk) begin
			has_open <= '0;
		end else begin
			has_open <= (has_open | open_i) & ~close_i; // A close wins over an open.
		end
	end

	always_ff @(posedge sdram_rst) begin
		for (int b = 0; b < sdram_sched_pkg::BANK_N; b++) begin
			if (open_i[b]) begin
				open_rows[b] <= row_o;
			end
		end
	end

	assign bank_open_o = has_open[bank_o];
	assign page_hit_o = bank_open_o & (open_rows[bank_o] == row_o);

endmodule

// File: design/timing_counters.sv
`timescale 1ns/1ps

module timing_counters (
	input  logic        sdram_rst,
	input  logic        sys_clk,
	input  logic [2:0]  tim_rp_i,
	input  logic [2:0]  tim_rcd_i,
	input  logic        tim_cas_i,
	input  logic [10:0] tim_refi_i,
	input  logic [3:0]  tim_rfc_i,
	input  logic        load_precharge_i,
	input  logic        load_activate_i,
	input  logic        load_read_i,
	input  logic        load_write_i,
	input  logic        load_refresh_i,
	output logic        precharge_done_o,
	output logic        activate_done_o,
	output logic        autorefresh_done_o,
	output logic        must_refresh_o,
	output logic        read_done_o,
	output logic        write_done_o,
	output logic        op_read_o,
	output logic        op_write_o
);

	logic [2:0]  precharge_cnt;
	logic [2:0]  activate_cnt;
	logic [1:0]  cas_cnt;
	logic [10:0] refresh_cnt;
	logic [3:0]  autorefresh_cnt;
	logic [2:0]  read_cnt;
	logic [2:0]  write_cnt;
	logic        start_read;

	assign precharge_done_o = (precharge_cnt == 3'd0);
	assign activate_done_o = (activate_cnt == 3'd0);
	assign autorefresh_done_o = (autorefresh_cnt == 4'd0);
	assign must_refresh_o = (refresh_cnt == 11'd0); // Also true straight out of reset.
	assign read_done_o = (read_cnt == 3'd0);
	assign write_done_o = (write_cnt == 3'd0);
	assign op_read_o = ~read_done_o;
	assign op_write_o = ~write_done_o;
	assign start_read = (cas_cnt == 2'd1);

	always_ff @(posedge sdram_rst or posedge sys_clk) begin
		if (sys_clk) begin
			precharge_cnt   <= '0;
			activate_cnt    <= '0;
			cas_cnt         <= '0;
			refresh_cnt     <= '0;
			autorefresh_cnt <= '0;
			read_cnt        <= '0;
			write_cnt       <= '0;
		end else begin
			if (load_precharge_i) begin
				precharge_cnt <= tim_rp_i;
			end else if (!precharge_done_o) begin
				precharge_cnt <= precharge_cnt - 3'd1;
			end
			if (load_activate_i) begin
				activate_cnt <= tim_rcd_i;
			end else if (!activate_done_o) begin
				activate_cnt <= activate_cnt - 3'd1;
			end
			if (load_refresh_i) begin
				refresh_cnt     <= tim_refi_i;
				autorefresh_cnt <= tim_rfc_i;
			end else begin
				refresh_cnt     <= must_refresh_o ? refresh_cnt : refresh_cnt - 11'd1;
				autorefresh_cnt <= autorefresh_done_o ? autorefresh_cnt : autorefresh_cnt - 4'd1;
			end
			// Read window opens 2 or 3 cycles after READ, depending on CAS latency.
			if (load_read_i) begin
				cas_cnt <= {tim_cas_i, ~tim_cas_i};
			end else if (cas_cnt != 2'd0) begin
				cas_cnt <= cas_cnt - 2'd1;
			end
			if (start_read) begin
				read_cnt <= 3'(sdram_sched_pkg::READ_BURST_LEN);
			end else if (!read_done_o) begin
				read_cnt <= read_cnt - 3'd1;
			end
			if (load_write_i) begin
				write_cnt <= 3'(sdram_sched_pkg::WRITE_BURST_LEN); // Window starts next cycle.
			end else if (!write_done_o) begin
				write_cnt <= write_cnt - 3'd1;
			end
		end
	end

endmodule

// File: design/command_fsm.sv
`timescale 1ns/1ps

module command_fsm (
	input  logic                                sdram_rst,
	input  logic                                sys_clk,
	sched_req_if.cmd                            q,
	input  sdram_sched_pkg::row_t               row_i,
	input  sdram_sched_pkg::col_t               col_i,
	input  sdram_sched_pkg::bank_t              bank_i,
	input  logic                                bank_open_i,
	input  logic                                page_hit_i,
	input  logic                                precharge_done_i,
	input  logic                                activate_done_i,
	input  logic                                autorefresh_done_i,
	input  logic                                read_done_i,
	input  logic                                write_done_i,
	input  logic                                must_refresh_i,
	output logic                                load_precharge_o,
	output logic                                load_activate_o,
	output logic                                load_read_o,
	output logic                                load_write_o,
	output logic                                load_refresh_o,
	output logic [sdram_sched_pkg::BANK_N-1:0] open_o,
	output logic [sdram_sched_pkg::BANK_N-1:0] close_o,
	output logic                                cs_n_o,
	output logic                                ras_n_o,
	output logic                                cas_n_o,
	output logic                                we_n_o,
	output logic [12:0]                         adr_o,
	output sdram_sched_pkg::bank_t              ba_o
);

	sdram_sched_pkg::cmd_state_t state;
	sdram_sched_pkg::cmd_state_t next_state;
	sdram_sched_pkg::sdram_cmd_t cmd;
	logic                        col_ok;
	logic                        do_activate;
	logic                        do_column;
	logic                        sel_row;
	logic                        sel_col;
	logic                        sel_a10;

	always_ff @(posedge sdram_rst or posedge sys_clk) begin
		if (sys_clk) begin
			state <= sdram_sched_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	// A column command waits for the other data window and for a free issued slot.
	assign col_ok = q.head_we ? (read_done_i & (~q.write_pending | q.clear_fetch))
		: (write_done_i & (~q.read_pending | q.clear_fetch));

	always_comb begin
		next_state = state;
		cmd = sdram_sched_pkg::CMD_NOP;
		do_activate = 1'b0;
		do_column = 1'b0;
		load_precharge_o = 1'b0;
		load_refresh_o = 1'b0;
		close_o = '0;
		case (state)
			sdram_sched_pkg::IDLE: begin
				if (must_refresh_i) begin
					next_state = sdram_sched_pkg::PRECHARGEALL;
				end else if (q.head_valid) begin
					if (page_hit_i) begin
						do_column = col_ok;
					end else if (bank_open_i) begin
						cmd = sdram_sched_pkg::CMD_PRECHARGE; // Row miss closes only this bank.
						close_o[bank_i] = 1'b1;
						load_precharge_o = 1'b1;
						next_state = sdram_sched_pkg::ACTIVATE;
					end else begin
						do_activate = 1'b1;
					end
				end
			end
			sdram_sched_pkg::ACTIVATE: do_activate = precharge_done_i;
			sdram_sched_pkg::READ, sdram_sched_pkg::WRITE: begin
				if (activate_done_i) begin
					if (must_refresh_i) begin
						next_state = sdram_sched_pkg::PRECHARGEALL; // Refresh goes first.
					end else if (col_ok) begin
						do_column = 1'b1;
						next_state = sdram_sched_pkg::IDLE;
					end
				end
			end
			sdram_sched_pkg::PRECHARGEALL: begin
				cmd = sdram_sched_pkg::CMD_PRECHARGE;
				load_precharge_o = 1'b1;
				next_state = sdram_sched_pkg::AUTOREFRESH;
			end
			sdram_sched_pkg::AUTOREFRESH: begin
				close_o = '1;
				if (precharge_done_i) begin
					cmd = sdram_sched_pkg::CMD_REFRESH;
					load_refresh_o = 1'b1;
					next_state = sdram_sched_pkg::AUTOREFRESH_WAIT;
				end
			end
			sdram_sched_pkg::AUTOREFRESH_WAIT: begin
				if (autorefresh_done_i) begin
					next_state = sdram_sched_pkg::IDLE;
				end
			end
			default: next_state = sdram_sched_pkg::IDLE;
		endcase
		if (do_activate) begin
			cmd = sdram_sched_pkg::CMD_ACTIVATE;
			next_state = q.head_we ? sdram_sched_pkg::WRITE : sdram_sched_pkg::READ;
		end
		if (do_column) begin
			cmd = q.head_we ? sdram_sched_pkg::CMD_WRITE : sdram_sched_pkg::CMD_READ;
		end
	end

	assign open_o = do_activate ? (sdram_sched_pkg::BANK_N)'(1) << bank_i : '0;
	assign load_activate_o = do_activate;
	assign load_read_o = do_column & ~q.head_we;
	assign load_write_o = do_column & q.head_we;
	assign q.advance = do_column; // Head leaves the queue with its column command.

	assign sel_row = do_activate;
	assign sel_col = do_column;
	assign sel_a10 = (state == sdram_sched_pkg::PRECHARGEALL);
	assign adr_o = sel_row ? row_i
		: sel_col ? sdram_sched_pkg::row_t'(col_i)
		: sel_a10 ? sdram_sched_pkg::A10_ALL : '0;
	assign ba_o = bank_i;

	assign cs_n_o = ~cmd.cs;
	assign ras_n_o = ~cmd.ras;
	assign cas_n_o = ~cmd.cas;
	assign we_n_o = ~cmd.we;

endmodule

// File: design/bus_responder.sv
`timescale 1ns/1ps

module bus_responder (
	input  logic                       sdram_rst,
	input  logic                       sys_clk,
	input  logic                       req_i,
	input  logic                       we_i,
	input  sdram_sched_pkg::word_adr_t adr_i,
	input  logic                       tim_cas_i,
	sched_req_if.bus                   q,
	output logic                       ack_o,
	output logic                       buffer_r_next_o,
	output logic                       buffer_w_next_o
);

	sdram_sched_pkg::bus_state_t wstate;
	sdram_sched_pkg::bus_state_t next_wstate;
	logic [1:0]                  avail_cnt;
	logic                        fetch_avail;

	always_ff @(posedge sdram_rst or posedge sys_clk) begin
		if (sys_clk) begin
			wstate    <= sdram_sched_pkg::WIDLE;
			avail_cnt <= 2'd2;
		end else begin
			wstate <= next_wstate;
			if (!q.read_pending) begin
				avail_cnt <= {1'b1, tim_cas_i}; // Read data is ready 2 or 3 cycles later.
			end else if (!fetch_avail) begin
				avail_cnt <= avail_cnt - 2'd1;
			end
		end
	end

	assign fetch_avail = (avail_cnt == 2'd0);

	always_comb begin
		next_wstate = wstate;
		ack_o = 1'b0;
		q.clear_fetch = 1'b0;
		buffer_r_next_o = 1'b0;
		buffer_w_next_o = 1'b0;
		case (wstate)
			sdram_sched_pkg::WIDLE: begin
				if (req_i) begin
					next_wstate = we_i ? sdram_sched_pkg::WPROCESS_WRITE
						: sdram_sched_pkg::WPROCESS_READ;
				end
			end
			sdram_sched_pkg::WPROCESS_READ: begin
				if (fetch_avail) begin
					q.clear_fetch = 1'b1; // A read for another address is discarded.
					if (q.fetched_adr == adr_i) begin
						ack_o = 1'b1;
						buffer_r_next_o = 1'b1;
						next_wstate = sdram_sched_pkg::WIDLE;
					end
				end
			end
			sdram_sched_pkg::WPROCESS_WRITE: begin
				if (q.write_pending) begin
					q.clear_fetch = 1'b1;
					ack_o = 1'b1;
					buffer_w_next_o = 1'b1;
					next_wstate = sdram_sched_pkg::WIDLE;
				end
			end
			default: next_wstate = sdram_sched_pkg::WIDLE;
		endcase
	end

endmodule

// File: design/sdram_scheduler.sv
`timescale 1ns/1ps

module sdram_scheduler (
	input  logic                   sdram_rst,
	input  logic                   sys_clk,
	input  logic [31:0]            wb_adr_i,
	input  logic                   wb_we_i,
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	output logic                   wb_ack_o,
	input  logic [2:0]             tim_rp_i,
	input  logic [2:0]             tim_rcd_i,
	input  logic                   tim_cas_i,
	input  logic [10:0]            tim_refi_i,
	input  logic [3:0]             tim_rfc_i,
	output logic                   sdram_cs_n_o,
	output logic                   sdram_ras_n_o,
	output logic                   sdram_cas_n_o,
	output logic                   sdram_we_n_o,
	output logic [12:0]            sdram_adr_o,
	output sdram_sched_pkg::bank_t sdram_ba_o,
	output logic                   op_read_o,
	output logic                   op_write_o,
	output logic                   buffer_r_next_o,
	output logic                   buffer_w_next_o
);

	logic                                bus_req;
	sdram_sched_pkg::row_t               row;
	sdram_sched_pkg::col_t               col;
	sdram_sched_pkg::bank_t              bank;
	logic                                bank_open;
	logic                                page_hit;
	logic [sdram_sched_pkg::BANK_N-1:0] open_bank;
	logic [sdram_sched_pkg::BANK_N-1:0] close_bank;
	logic                                precharge_done;
	logic                                activate_done;
	logic                                autorefresh_done;
	logic                                must_refresh;
	logic                                read_done;
	logic                                write_done;
	logic                                load_precharge;
	logic                                load_activate;
	logic                                load_read;
	logic                                load_write;
	logic                                load_refresh;

	assign bus_req = wb_cyc_i & wb_stb_i;

	sched_req_if #(.ADR_W(sdram_sched_pkg::WORD_W)) req_if_i ();

	fetch_queue fetch_queue_i (
		.sdram_rst(sdram_rst), .sys_clk(sys_clk), .adr_i(wb_adr_i), .we_i(wb_we_i),
		.req_i(bus_req), .ack_i(wb_ack_o), .q(req_if_i.queue)
	);

	open_row_tracker open_row_tracker_i (
		.sdram_rst(sdram_rst), .sys_clk(sys_clk), .head_adr_i(req_if_i.head_adr),
		.open_i(open_bank), .close_i(close_bank), .row_o(row), .col_o(col), .bank_o(bank),
		.bank_open_o(bank_open), .page_hit_o(page_hit)
	);

	timing_counters timing_counters_i (
		.sdram_rst(sdram_rst), .sys_clk(sys_clk), .tim_rp_i(tim_rp_i), .tim_rcd_i(tim_rcd_i),
		.tim_cas_i(tim_cas_i), .tim_refi_i(tim_refi_i), .tim_rfc_i(tim_rfc_i),
		.load_precharge_i(load_precharge), .load_activate_i(load_activate),
		.load_read_i(load_read), .load_write_i(load_write), .load_refresh_i(load_refresh),
		.precharge_done_o(precharge_done), .activate_done_o(activate_done),
		.autorefresh_done_o(autorefresh_done), .must_refresh_o(must_refresh),
		.read_done_o(read_done), .write_done_o(write_done),
		.op_read_o(op_read_o), .op_write_o(op_write_o)
	);

	command_fsm command_fsm_i (
		.sdram_rst(sdram_rst), .sys_clk(sys_clk), .q(req_if_i.cmd),
		.row_i(row), .col_i(col), .bank_i(bank), .bank_open_i(bank_open), .page_hit_i(page_hit),
		.precharge_done_i(precharge_done), .activate_done_i(activate_done),
		.autorefresh_done_i(autorefresh_done), .read_done_i(read_done),
		.write_done_i(write_done), .must_refresh_i(must_refresh),
		.load_precharge_o(load_precharge), .load_activate_o(load_activate),
		.load_read_o(load_read), .load_write_o(load_write), .load_refresh_o(load_refresh),
		.open_o(open_bank), .close_o(close_bank),
		.cs_n_o(sdram_cs_n_o), .ras_n_o(sdram_ras_n_o), .cas_n_o(sdram_cas_n_o),
		.we_n_o(sdram_we_n_o), .adr_o(sdram_adr_o), .ba_o(sdram_ba_o)
	);

	// The bus holds its address until acknowledge, so it is compared unregistered.
	bus_responder bus_responder_i (
		.sdram_rst(sdram_rst), .sys_clk(sys_clk), .req_i(bus_req), .we_i(wb_we_i),
		.adr_i(wb_adr_i[sdram_sched_pkg::SDRAM_DEPTH-1:3]), .tim_cas_i(tim_cas_i),
		.q(req_if_i.bus), .ack_o(wb_ack_o),
		.buffer_r_next_o(buffer_r_next_o), .buffer_w_next_o(buffer_w_next_o)
	);

endmodule

// File: tb/tb_sdram_scheduler.sv
`timescale 1ns/1ps

module tb_sdram_scheduler;

	localparam int N_ENTRIES = 8;
	localparam int CYCLE_LIMIT = N_ENTRIES * 80 + 100;
	localparam int SEED = 32'h6067926c;
	localparam int BURST_LEN = 4; // Data window length for reads and writes.
	localparam logic [2:0] TIM_RP = 3'd2;
	localparam logic [2:0] TIM_RCD = 3'd2;
	localparam logic TIM_CAS = 1'b0;
	localparam logic [3:0] TIM_RFC = 4'd6;
	localparam logic [10:0] TIM_REFI = 11'd300;

	typedef enum logic [2:0] {K_ACT, K_RD, K_WR, K_PRE, K_PREA, K_REF, K_BAD} kind_t;

	typedef struct {
		logic        we;
		logic [12:0] row;
		logic [1:0]  bank;
		logic        wait_ref; // Start only after the next periodic refresh.
		logic        exp_pre;
		logic        exp_act;
	} entry_t;

	logic        sdram_rst;
	logic        sys_clk;
	logic [31:0] wb_adr;
	logic        wb_we;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_ack;
	logic        cs_n;
	logic        ras_n;
	logic        cas_n;
	logic        we_n;
	logic [12:0] sd_adr;
	logic [1:0]  sd_ba;
	logic        op_read;
	logic        op_write;
	logic        buf_r;
	logic        buf_w;

	int          cycle = 0;
	int          errors = 0;
	int          checks = 0;
	kind_t       log_kind[$]; // Every command seen on the pins, in order.
	int          log_cyc[$];
	logic [12:0] log_adr[$];
	logic [1:0]  log_ba[$];
	int          ref_count = 0;
	int          last_ref_cyc = 0;
	int          ack_count = 0;
	int          ack_cyc = 0;
	logic        ack_r = 1'b0;
	logic        ack_w = 1'b0;
	int          rd_run = 0;
	int          rd_start = 0;
	int          rd_len[$];
	int          rd_first[$];
	int          wr_run = 0;
	int          wr_start = 0;
	int          wr_len[$];
	int          wr_first[$];
	logic        open_valid[4] = '{4{1'b0}}; // Reference model of the open rows.
	logic [12:0] open_row[4];
	entry_t      tbl[N_ENTRIES];

	sdram_scheduler dut_i (
		.sdram_rst(sdram_rst), .sys_clk(sys_clk), .wb_adr_i(wb_adr), .wb_we_i(wb_we),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_ack_o(wb_ack),
		.tim_rp_i(TIM_RP), .tim_rcd_i(TIM_RCD), .tim_cas_i(TIM_CAS),
		.tim_refi_i(TIM_REFI), .tim_rfc_i(TIM_RFC),
		.sdram_cs_n_o(cs_n), .sdram_ras_n_o(ras_n), .sdram_cas_n_o(cas_n),
		.sdram_we_n_o(we_n), .sdram_adr_o(sd_adr), .sdram_ba_o(sd_ba),
		.op_read_o(op_read), .op_write_o(op_write),
		.buffer_r_next_o(buf_r), .buffer_w_next_o(buf_w)
	);

	initial begin
		sdram_rst = 1'b0;
		forever #5 sdram_rst = ~sdram_rst;
	end

	task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_true(logic ok, string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("Error at %0d ns: %s", $time, what);
		end
	endtask

	// Row, then bank, then column over 32-bit words; bit 2 of the byte address stays clear.
	function automatic logic [31:0] make_address(logic [12:0] row, logic [1:0] bank,
		logic [7:0] col);
		return {7'd0, row, bank, col, 2'b00};
	endfunction

	// Samples at the rising edge, where every registered output is settled.
	always @(posedge sdram_rst) begin
		kind_t k;
		if (!cs_n) begin
			case ({ras_n, cas_n, we_n})
				3'b011: k = K_ACT;
				3'b101: k = K_RD;
				3'b100: k = K_WR;
				3'b010: k = sd_adr[10] ? K_PREA : K_PRE;
				3'b001: k = K_REF;
				default: k = K_BAD;
			endcase
			check_true(k != K_BAD, "illegal command pattern on the SDRAM pins");
			if (k == K_REF) begin
				check_true(log_kind.size() > 0 && log_kind[$] == K_PREA,
					"AUTO REFRESH was not preceded by PRECHARGE ALL");
				check_true(log_kind.size() > 0 && cycle - log_cyc[$] >= int'(TIM_RP),
					"AUTO REFRESH came less than tRP after PRECHARGE ALL");
				if (ref_count > 0) begin
					check_true(cycle - last_ref_cyc >= int'(TIM_REFI),
						"refresh repeated before tREFI had expired");
				end
				open_valid = '{4{1'b0}}; // All rows are closed by the refresh.
				last_ref_cyc = cycle;
				ref_count++;
			end
			log_kind.push_back(k);
			log_cyc.push_back(cycle);
			log_adr.push_back(sd_adr);
			log_ba.push_back(sd_ba);
		end
		if (wb_ack) begin
			ack_count++;
			ack_cyc = cycle;
			ack_r = buf_r;
			ack_w = buf_w;
		end else begin
			check_true(!buf_r && !buf_w, "buffer strobe pulsed without an acknowledge");
		end
		if (op_read) begin
			if (rd_run == 0) begin
				rd_start = cycle;
			end
			rd_run++;
		end else if (rd_run != 0) begin
			rd_len.push_back(rd_run); // A read window has just closed.
			rd_first.push_back(rd_start);
			rd_run = 0;
		end
		if (op_write) begin
			if (wr_run == 0) begin
				wr_start = cycle;
			end
			wr_run++;
		end else if (wr_run != 0) begin
			wr_len.push_back(wr_run);
			wr_first.push_back(wr_start);
			wr_run = 0;
		end
		cycle++;
	end

	task automatic check_access(entry_t e, logic [7:0] col, int start, int rd_before,
		int wr_before);
		int    n_exp;
		int    k;
		int    col_cyc;
		kind_t col_kind;
		n_exp = 1 + int'(e.exp_pre) + int'(e.exp_act);
		col_kind = e.we ? K_WR : K_RD;
		compare_value("SDRAM command count", log_kind.size() - start, n_exp);
		if (log_kind.size() - start == n_exp) begin
			k = start;
			if (e.exp_pre) begin
				compare_value("PRECHARGE command", log_kind[k], K_PRE); // K_PRE means A10 clear.
				compare_value("sdram_ba_o", log_ba[k], e.bank);
				k++;
			end
			if (e.exp_act) begin
				compare_value("ACTIVATE command", log_kind[k], K_ACT);
				compare_value("sdram_adr_o", log_adr[k], e.row);
				compare_value("sdram_ba_o", log_ba[k], e.bank);
				if (e.exp_pre) begin
					check_true(log_cyc[k] - log_cyc[k-1] >= int'(TIM_RP),
						"ACTIVATE came less than tRP after PRECHARGE");
				end
				k++;
			end
			compare_value("column command", log_kind[k], col_kind);
			compare_value("sdram_adr_o", log_adr[k], col);
			compare_value("sdram_ba_o", log_ba[k], e.bank);
			if (e.exp_act) begin
				check_true(log_cyc[k] - log_cyc[k-1] >= int'(TIM_RCD),
					"column command came less than tRCD after ACTIVATE");
			end
			col_cyc = log_cyc[k];
			if (e.we) begin
				compare_value("wb_ack_o cycle", ack_cyc, col_cyc + 1);
				compare_value("buffer_w_next_o", ack_w, 1'b1);
				compare_value("buffer_r_next_o", ack_r, 1'b0);
				compare_value("op_write_o start", wr_first[$], col_cyc + 1);
				compare_value("op_write_o length", wr_len[$], BURST_LEN);
			end else begin
				compare_value("wb_ack_o cycle", ack_cyc, col_cyc + 3 + int'(TIM_CAS));
				compare_value("buffer_r_next_o", ack_r, 1'b1);
				compare_value("buffer_w_next_o", ack_w, 1'b0);
				compare_value("op_read_o start", rd_first[$], col_cyc + 2 + int'(TIM_CAS));
				compare_value("op_read_o length", rd_len[$], BURST_LEN);
			end
		end
		compare_value("op_read_o windows", rd_len.size() - rd_before, e.we ? 0 : 1);
		compare_value("op_write_o windows", wr_len.size() - wr_before, e.we ? 1 : 0);
	endtask

	initial begin
		wait (cycle >= CYCLE_LIMIT);
		$display("Timeout after %0d cycles; checks: %0d, errors: %0d", cycle, checks, errors);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		int          start;
		int          rd_before;
		int          wr_before;
		int          acks_before;
		int          refs_before;
		logic [7:0]  col;
		logic        model_pre;
		logic        model_act;
		void'($urandom(SEED));
		sys_clk = 1'b1;
		wb_adr = '0;
		wb_we = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		// Each entry holds we, row, bank, wait for refresh, expect PRECHARGE and expect ACTIVATE.
		tbl[0] = '{1'b0, 13'h0005, 2'd1, 1'b0, 1'b0, 1'b1}; // Closed bank.
		tbl[1] = '{1'b0, 13'h0005, 2'd1, 1'b0, 1'b0, 1'b0}; // Page hit.
		tbl[2] = '{1'b1, 13'h0005, 2'd1, 1'b0, 1'b0, 1'b0};
		tbl[3] = '{1'b0, 13'h0009, 2'd1, 1'b0, 1'b1, 1'b1}; // Row miss.
		tbl[4] = '{1'b1, 13'h01a3, 2'd2, 1'b0, 1'b0, 1'b1};
		tbl[5] = '{1'b0, 13'h01a3, 2'd2, 1'b0, 1'b0, 1'b0};
		tbl[6] = '{1'b0, 13'h0009, 2'd1, 1'b1, 1'b0, 1'b1}; // Row closed by the refresh.
		tbl[7] = '{1'b1, 13'h01a3, 2'd2, 1'b0, 1'b0, 1'b1};
		repeat (3) @(posedge sdram_rst);
		@(negedge sdram_rst);
		compare_value("wb_ack_o", wb_ack, 1'b0);
		compare_value("op_read_o", op_read, 1'b0);
		compare_value("op_write_o", op_write, 1'b0);
		compare_value("buffer_r_next_o", buf_r, 1'b0);
		compare_value("buffer_w_next_o", buf_w, 1'b0);
		compare_value("sdram_cs_n_o", cs_n, 1'b1);
		sys_clk = 1'b0;
		while (ref_count == 0) begin
			@(negedge sdram_rst);
		end
		compare_value("commands before first refresh", log_kind.size(), 2);
		if (log_kind.size() == 2) begin
			compare_value("first command", log_kind[0], K_PREA);
			compare_value("second command", log_kind[1], K_REF);
		end
		compare_value("acknowledges before first refresh", ack_count, 0);
		for (int i = 0; i < N_ENTRIES; i++) begin
			if (tbl[i].wait_ref) begin
				refs_before = ref_count;
				while (ref_count == refs_before) begin
					@(negedge sdram_rst);
				end
			end
			model_pre = open_valid[tbl[i].bank] && open_row[tbl[i].bank] != tbl[i].row;
			model_act = !(open_valid[tbl[i].bank] && open_row[tbl[i].bank] == tbl[i].row);
			check_true(model_pre == tbl[i].exp_pre && model_act == tbl[i].exp_act,
				"open-row model disagrees with the stimulus table");
			col = 8'($urandom) & 8'hfe; // Only even columns start a 64-bit word.
			start = log_kind.size();
			rd_before = rd_len.size();
			wr_before = wr_len.size();
			acks_before = ack_count;
			wb_adr = make_address(tbl[i].row, tbl[i].bank, col);
			wb_we = tbl[i].we;
			wb_cyc = 1'b1;
			wb_stb = 1'b1;
			while (ack_count == acks_before) begin
				@(negedge sdram_rst);
			end
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			while ((tbl[i].we ? wr_len.size() : rd_len.size()) ==
				(tbl[i].we ? wr_before : rd_before)) begin
				@(negedge sdram_rst); // Until the data window has closed.
			end
			check_access(tbl[i], col, start, rd_before, wr_before);
			open_valid[tbl[i].bank] = 1'b1;
			open_row[tbl[i].bank] = tbl[i].row;
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: list.f
design/sdram_sched_pkg.sv
design/sched_req_if.sv
design/fetch_queue.sv
design/open_row_tracker.sv
design/timing_counters.sv
design/command_fsm.sv
design/bus_responder.sv
design/sdram_scheduler.sv
tb/tb_sdram_scheduler.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_sdram_scheduler
FLIST = list.f
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
